// ==== Makefile ====
OBJ_DIR = obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert --timescale 1ns/1ps --top-module cpu_tb -f filelist.f --Mdir $(OBJ_DIR) -o cpu_tb

run: compile
	./$(OBJ_DIR)/cpu_tb

clean:
	rm -rf $(OBJ_DIR)

// ==== filelist.f ====
src/cpu_pkg.sv
src/fetch_stage.sv
src/decode_stage.sv
src/operand_bypass.sv
src/regfile.sv
src/alu.sv
src/execute_stage.sv
src/memory_writeback_stage.sv
src/cpu_top.sv
tests/cpu_asserts.sv
tests/cpu_tb.sv

// ==== src/alu.sv ====
`default_nettype none

module alu import cpu_pkg::*; (
    input  alu_op_e alu_op,
    input  word_t   src1,
    input  word_t   src2,
    output word_t   result
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = src2[4:0];
    assign lt_signed   = $signed(src1) < $signed(src2);
    assign lt_unsigned = src1 < src2;

    always_comb begin
        case (alu_op)
            alu_add:  result = src1 + src2;
            alu_sub:  result = src1 - src2;
            alu_slt:  result = {31'b0, lt_signed};
            alu_sltu: result = {31'b0, lt_unsigned};
            alu_and:  result = src1 & src2;
            alu_nor:  result = ~(src1 | src2);
            alu_or:   result = src1 | src2;
            alu_xor:  result = src1 ^ src2;
            alu_sll:  result = src1 << shamt;
            alu_srl:  result = src1 >> shamt;
            alu_sra:  result = $signed(src1) >>> shamt;
            // lu12i immediate is already shifted in decode
            alu_lui:  result = src2;
            default:  result = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== src/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_slt,
        alu_sltu,
        alu_and,
        alu_nor,
        alu_or,
        alu_xor,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_lui
    } alu_op_e;

    localparam reg_idx_t link_reg   = 5'd1;
    localparam word_t    inst_bytes = 32'd4;

    // inst[31:15], 3R and shift-immediate forms
    localparam logic [16:0] op_add_w  = 17'h00020;
    localparam logic [16:0] op_sub_w  = 17'h00022;
    localparam logic [16:0] op_slt    = 17'h00024;
    localparam logic [16:0] op_sltu   = 17'h00025;
    localparam logic [16:0] op_nor    = 17'h00028;
    localparam logic [16:0] op_and    = 17'h00029;
    localparam logic [16:0] op_or     = 17'h0002a;
    localparam logic [16:0] op_xor    = 17'h0002b;
    localparam logic [16:0] op_slli_w = 17'h00081;
    localparam logic [16:0] op_srli_w = 17'h00089;
    localparam logic [16:0] op_srai_w = 17'h00091;

    // inst[31:22]
    localparam logic [9:0] op_addi_w = 10'h00a;
    localparam logic [9:0] op_ld_w   = 10'h0a2;
    localparam logic [9:0] op_st_w   = 10'h0a6;

    // inst[31:25]
    localparam logic [6:0] op_lu12i_w = 7'h0a;

    // inst[31:26]
    localparam logic [5:0] op_jirl = 6'h13;
    localparam logic [5:0] op_b    = 6'h14;
    localparam logic [5:0] op_bl   = 6'h15;
    localparam logic [5:0] op_beq  = 6'h16;
    localparam logic [5:0] op_bne  = 6'h17;

endpackage

`default_nettype wire

// ==== src/cpu_top.sv ====
`default_nettype none

module cpu_top import cpu_pkg::*; #(
    parameter word_t reset_pc = 32'h1c000000
) (
    input  logic        clk,
    input  logic        reset,
    output logic        inst_sram_en,
    output logic [3:0]  inst_sram_we,
    output logic [31:0] inst_sram_addr,
    output logic [31:0] inst_sram_wdata,
    input  logic [31:0] inst_sram_rdata,
    output logic        data_sram_en,
    output logic [3:0]  data_sram_we,
    output logic [31:0] data_sram_addr,
    output logic [31:0] data_sram_wdata,
    input  logic [31:0] data_sram_rdata,
    output logic [31:0] debug_wb_pc,
    output logic [3:0]  debug_wb_rf_we,
    output logic [4:0]  debug_wb_rf_wnum,
    output logic [31:0] debug_wb_rf_wdata
);

    word_t    id_pc, id_inst, br_target;
    logic     id_valid, br_redirect, stall;
    reg_idx_t rf_raddr1, rf_raddr2;
    word_t    rf_rdata1, rf_rdata2, rj_value, rkd_value;
    logic     uses_rj, uses_rkd;
    logic     ex_valid, ex_rf_we, ex_is_load, ex_is_store;
    word_t    ex_pc, ex_src1, ex_src2, ex_store_data, ex_result;
    alu_op_e  ex_alu_op;
    reg_idx_t ex_dest;
    logic     mem_valid, mem_rf_we, mem_is_load;
    word_t    mem_pc, mem_alu_result, mem_result;
    reg_idx_t mem_dest;
    logic     wb_we;
    reg_idx_t wb_dest;
    word_t    wb_result;

    // instruction port is read only
    assign inst_sram_we    = 4'b0;
    assign inst_sram_wdata = 32'b0;

    fetch_stage #(.reset_pc(reset_pc)) fetch0 (.*);

    decode_stage decode0 (.*);

    operand_bypass bypass0 (.*);

    regfile regfile0 (
        .clk    (clk),
        .raddr1 (rf_raddr1),
        .raddr2 (rf_raddr2),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .we     (wb_we),
        .waddr  (wb_dest),
        .wdata  (wb_result)
    );

    execute_stage execute0 (.*);

    memory_writeback_stage mem_wb0 (.*);

endmodule

`default_nettype wire

// ==== src/decode_stage.sv ====
`default_nettype none

module decode_stage import cpu_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  word_t    id_pc,
    input  word_t    id_inst,
    input  logic     id_valid,
    input  word_t    rj_value,
    input  word_t    rkd_value,
    input  logic     stall,
    output reg_idx_t rf_raddr1,
    output reg_idx_t rf_raddr2,
    output logic     uses_rj,
    output logic     uses_rkd,
    output logic     br_redirect,
    output word_t    br_target,
    output logic     ex_valid,
    output word_t    ex_pc,
    output alu_op_e  ex_alu_op,
    output word_t    ex_src1,
    output word_t    ex_src2,
    output word_t    ex_store_data,
    output reg_idx_t ex_dest,
    output logic     ex_rf_we,
    output logic     ex_is_load,
    output logic     ex_is_store
);

    reg_idx_t rd;
    reg_idx_t rj;
    reg_idx_t rk;
    alu_op_e  r_op;
    alu_op_e  alu_op;
    logic     r_hit;
    logic     is_rr, is_shift, is_addi, is_ld, is_st, is_lu12i;
    logic     is_jirl, is_b, is_bl, is_beq, is_bne;
    logic     src1_is_pc, src2_is_imm, rkd_is_rd, gr_we;
    logic     rj_eq_rkd, br_taken;
    word_t    imm;
    word_t    offs16;
    word_t    offs26;

    assign rd = id_inst[4:0];
    assign rj = id_inst[9:5];
    assign rk = id_inst[14:10];

    // register and shift-immediate forms share inst[31:15]
    always_comb begin
        r_op  = alu_add;
        r_hit = 1'b1;
        case (id_inst[31:15])
            op_add_w:  r_op = alu_add;
            op_sub_w:  r_op = alu_sub;
            op_slt:    r_op = alu_slt;
            op_sltu:   r_op = alu_sltu;
            op_nor:    r_op = alu_nor;
            op_and:    r_op = alu_and;
            op_or:     r_op = alu_or;
            op_xor:    r_op = alu_xor;
            op_slli_w: r_op = alu_sll;
            op_srli_w: r_op = alu_srl;
            op_srai_w: r_op = alu_sra;
            default:   r_hit = 1'b0;
        endcase
    end

    assign is_shift = r_hit & (r_op inside {alu_sll, alu_srl, alu_sra});
    assign is_rr    = r_hit & ~is_shift;
    assign is_addi  = id_inst[31:22] == op_addi_w;
    assign is_ld    = id_inst[31:22] == op_ld_w;
    assign is_st    = id_inst[31:22] == op_st_w;
    assign is_lu12i = id_inst[31:25] == op_lu12i_w;
    assign is_jirl  = id_inst[31:26] == op_jirl;
    assign is_b     = id_inst[31:26] == op_b;
    assign is_bl    = id_inst[31:26] == op_bl;
    assign is_beq   = id_inst[31:26] == op_beq;
    assign is_bne   = id_inst[31:26] == op_bne;

    assign src1_is_pc  = is_jirl | is_bl;
    assign src2_is_imm = is_shift | is_addi | is_ld | is_st | is_lu12i | src1_is_pc;
    assign rkd_is_rd   = is_st | is_beq | is_bne;
    assign gr_we       = r_hit | is_addi | is_ld | is_lu12i | src1_is_pc;

    assign alu_op = r_hit ? r_op : (is_lu12i ? alu_lui : alu_add);

    // link value is pc + 4, formed in the ALU
    assign imm = src1_is_pc ? inst_bytes :
                 is_lu12i   ? {id_inst[24:5], 12'b0} :
                              {{20{id_inst[21]}}, id_inst[21:10]};

    assign offs16 = {{14{id_inst[25]}}, id_inst[25:10], 2'b00};
    assign offs26 = {{4{id_inst[9]}}, id_inst[9:0], id_inst[25:10], 2'b00};

    assign rf_raddr1 = rj;
    assign rf_raddr2 = rkd_is_rd ? rd : rk;
    assign uses_rj   = id_valid & (r_hit | is_addi | is_ld | is_st | is_jirl | is_beq | is_bne);
    assign uses_rkd  = id_valid & (is_rr | rkd_is_rd);

    assign rj_eq_rkd   = rj_value == rkd_value;
    assign br_taken    = (is_beq & rj_eq_rkd) | (is_bne & ~rj_eq_rkd) | is_jirl | is_b | is_bl;
    assign br_redirect = br_taken & id_valid & ~stall;
    assign br_target   = is_jirl ? rj_value + offs16 :
                                   id_pc + ((is_b | is_bl) ? offs26 : offs16);

    // bubble into EX while the load-use stall holds decode
    always_ff @(posedge clk) begin
        if (reset) begin
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= id_valid & ~stall;
        end
    end

    always_ff @(posedge clk) begin
        ex_pc         <= id_pc;
        ex_alu_op     <= alu_op;
        ex_src1       <= src1_is_pc ? id_pc : rj_value;
        ex_src2       <= src2_is_imm ? imm : rkd_value;
        ex_store_data <= rkd_value;
        ex_dest       <= is_bl ? link_reg : rd;
        ex_rf_we      <= gr_we;
        ex_is_load    <= is_ld;
        ex_is_store   <= is_st;
    end

endmodule

`default_nettype wire

// ==== src/execute_stage.sv ====
`default_nettype none

module execute_stage import cpu_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       ex_valid,
    input  word_t      ex_pc,
    input  alu_op_e    ex_alu_op,
    input  word_t      ex_src1,
    input  word_t      ex_src2,
    input  word_t      ex_store_data,
    input  reg_idx_t   ex_dest,
    input  logic       ex_rf_we,
    input  logic       ex_is_load,
    input  logic       ex_is_store,
    output word_t      ex_result,
    output logic       data_sram_en,
    output logic [3:0] data_sram_we,
    output word_t      data_sram_addr,
    output word_t      data_sram_wdata,
    output logic       mem_valid,
    output word_t      mem_pc,
    output reg_idx_t   mem_dest,
    output logic       mem_rf_we,
    output logic       mem_is_load,
    output word_t      mem_alu_result
);

    alu alu0 (
        .alu_op (ex_alu_op),
        .src1   (ex_src1),
        .src2   (ex_src2),
        .result (ex_result)
    );

    // address is the rj + si12 sum, word stores only
    assign data_sram_en    = ex_valid & (ex_is_load | ex_is_store);
    assign data_sram_we    = {4{ex_valid & ex_is_store}};
    assign data_sram_addr  = ex_result;
    assign data_sram_wdata = ex_store_data;

    always_ff @(posedge clk) begin
        if (reset) begin
            mem_valid <= 1'b0;
        end else begin
            mem_valid <= ex_valid;
        end
    end

    always_ff @(posedge clk) begin
        mem_pc         <= ex_pc;
        mem_dest       <= ex_dest;
        mem_rf_we      <= ex_rf_we;
        mem_is_load    <= ex_is_load;
        mem_alu_result <= ex_result;
    end

endmodule

`default_nettype wire

// ==== src/fetch_stage.sv ====
`default_nettype none

module fetch_stage import cpu_pkg::*; #(
    parameter word_t reset_pc = 32'h1c000000
) (
    input  logic  clk,
    input  logic  reset,
    input  logic  stall,
    input  logic  br_redirect,
    input  word_t br_target,
    input  word_t inst_sram_rdata,
    output logic  inst_sram_en,
    output word_t inst_sram_addr,
    output word_t id_pc,
    output word_t id_inst,
    output logic  id_valid
);

    word_t pc;
    word_t held_inst;
    logic  use_held;

    assign inst_sram_en   = ~reset;
    assign inst_sram_addr = pc;

    // sram re-reads the held pc during a stall, so decode keeps its own copy
    assign id_inst = use_held ? held_inst : inst_sram_rdata;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc       <= reset_pc;
            id_valid <= 1'b0;
            use_held <= 1'b0;
        end else begin
            use_held <= stall;
            if (br_redirect) begin
                pc       <= br_target;
                // cancels the slot fetched behind the branch
                id_valid <= 1'b0;
            end else if (!stall) begin
                pc       <= pc + inst_bytes;
                id_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (stall) begin
            held_inst <= id_inst;
        end else begin
            id_pc <= pc;
        end
    end

endmodule

`default_nettype wire

// ==== src/memory_writeback_stage.sv ====
`default_nettype none

module memory_writeback_stage import cpu_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       mem_valid,
    input  word_t      mem_pc,
    input  reg_idx_t   mem_dest,
    input  logic       mem_rf_we,
    input  logic       mem_is_load,
    input  word_t      mem_alu_result,
    input  word_t      data_sram_rdata,
    output word_t      mem_result,
    output logic       wb_we,
    output reg_idx_t   wb_dest,
    output word_t      wb_result,
    output word_t      debug_wb_pc,
    output logic [3:0] debug_wb_rf_we,
    output reg_idx_t   debug_wb_rf_wnum,
    output word_t      debug_wb_rf_wdata
);

    logic  wb_valid;
    logic  wb_rf_we;
    word_t wb_pc;

    // sram answers a load one cycle after EX issued it
    assign mem_result = mem_is_load ? data_sram_rdata : mem_alu_result;

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= mem_valid;
        end
    end

    always_ff @(posedge clk) begin
        wb_pc     <= mem_pc;
        wb_dest   <= mem_dest;
        wb_rf_we  <= mem_rf_we;
        wb_result <= mem_result;
    end

    assign wb_we = wb_valid & wb_rf_we;

    assign debug_wb_pc       = wb_pc;
    assign debug_wb_rf_we    = {4{wb_we}};
    assign debug_wb_rf_wnum  = wb_dest;
    assign debug_wb_rf_wdata = wb_result;

endmodule

`default_nettype wire

// ==== src/operand_bypass.sv ====
`default_nettype none

module operand_bypass import cpu_pkg::*; (
    input  reg_idx_t rf_raddr1,
    input  reg_idx_t rf_raddr2,
    input  logic     uses_rj,
    input  logic     uses_rkd,
    input  word_t    rf_rdata1,
    input  word_t    rf_rdata2,
    input  logic     ex_valid,
    input  reg_idx_t ex_dest,
    input  logic     ex_rf_we,
    input  logic     ex_is_load,
    input  word_t    ex_result,
    input  logic     mem_valid,
    input  reg_idx_t mem_dest,
    input  logic     mem_rf_we,
    input  word_t    mem_result,
    input  logic     wb_we,
    input  reg_idx_t wb_dest,
    input  word_t    wb_result,
    output word_t    rj_value,
    output word_t    rkd_value,
    output logic     stall
);

    logic ex_fwd;
    logic mem_fwd;
    logic wb_fwd;
    logic load_in_ex;

    // r0 never forwards, so a zero dest disables each source
    assign ex_fwd     = ex_valid & ex_rf_we & ~ex_is_load & (ex_dest != '0);
    assign mem_fwd    = mem_valid & mem_rf_we & (mem_dest != '0);
    assign wb_fwd     = wb_we & (wb_dest != '0);
    assign load_in_ex = ex_valid & ex_is_load & ex_rf_we & (ex_dest != '0);

    // youngest producer wins
    function automatic word_t select_source(input reg_idx_t addr, input word_t rf_value);
        word_t value;
        if (ex_fwd && ex_dest == addr) begin
            value = ex_result;
        end else if (mem_fwd && mem_dest == addr) begin
            value = mem_result;
        end else if (wb_fwd && wb_dest == addr) begin
            value = wb_result;
        end else begin
            value = rf_value;
        end
        return value;
    endfunction

    always_comb begin
        rj_value  = select_source(rf_raddr1, rf_rdata1);
        rkd_value = select_source(rf_raddr2, rf_rdata2);
    end

    // load data only exists from MEM on
    assign stall = load_in_ex & ((uses_rj & (rf_raddr1 == ex_dest)) |
                                 (uses_rkd & (rf_raddr2 == ex_dest)));

endmodule

`default_nettype wire

// ==== src/regfile.sv ====
`default_nettype none

module regfile import cpu_pkg::*; (
    input  logic     clk,
    input  reg_idx_t raddr1,
    input  reg_idx_t raddr2,
    output word_t    rdata1,
    output word_t    rdata2,
    input  logic     we,
    input  reg_idx_t waddr,
    input  word_t    wdata
);

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // r0 is hardwired to zero
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

// ==== tests/cpu_asserts.sv ====
`default_nettype none

module cpu_asserts (
    input logic        clk,
    input logic        reset,
    input logic        data_sram_en,
    input logic [3:0]  data_sram_we,
    input logic [31:0] data_sram_addr,
    input logic [3:0]  debug_wb_rf_we
);
    timeunit 1ns;
    timeprecision 1ps;

    // byte enables only ride on an enabled access
    we_needs_en: assert property (
        @(posedge clk) !data_sram_en |-> data_sram_we == 4'h0
    ) else $error("data_sram_we set while data_sram_en is low");

    // trace enable is one bit repeated
    trace_we_uniform: assert property (
        @(posedge clk) debug_wb_rf_we == 4'h0 || debug_wb_rf_we == 4'hf
    ) else $error("debug_wb_rf_we is neither all ones nor all zero");

    // word accesses only
    addr_aligned: assert property (
        @(posedge clk) data_sram_en |-> data_sram_addr[1:0] == 2'b00
    ) else $error("data_sram_addr not word aligned on an access");

    // registers take the reset value at the first reset edge
    quiet_in_reset: assert property (
        @(posedge clk) reset && $past(reset) |-> !data_sram_en && debug_wb_rf_we == 4'h0
    ) else $error("memory access or register write while reset is high");

endmodule

bind cpu_top cpu_asserts asserts0 (
    .clk            (clk),
    .reset          (reset),
    .data_sram_en   (data_sram_en),
    .data_sram_we   (data_sram_we),
    .data_sram_addr (data_sram_addr),
    .debug_wb_rf_we (debug_wb_rf_we)
);

`default_nettype wire

// ==== tests/cpu_tb.sv ====
`default_nettype none

module cpu_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [31:0] reset_pc    = 32'h1c000000;
    localparam logic [31:0] loop_pc     = reset_pc + 32'h78;
    localparam int          cycle_limit = 400;

    logic        clk;
    logic        reset;
    logic        inst_sram_en;
    logic [3:0]  inst_sram_we;
    logic [31:0] inst_sram_addr;
    logic [31:0] inst_sram_wdata;
    logic [31:0] inst_sram_rdata;
    logic        data_sram_en;
    logic [3:0]  data_sram_we;
    logic [31:0] data_sram_addr;
    logic [31:0] data_sram_wdata;
    logic [31:0] data_sram_rdata;
    logic [31:0] debug_wb_pc;
    logic [3:0]  debug_wb_rf_we;
    logic [4:0]  debug_wb_rf_wnum;
    logic [31:0] debug_wb_rf_wdata;

    logic [31:0] prog [$];
    logic [31:0] exp_pc [$];
    logic [4:0]  exp_num [$];
    logic [31:0] exp_data [$];
    logic [31:0] dmem [256];
    int          trace_idx = 0;
    int          cycles = 0;
    bit          passed = 1'b0;
    bit          failed = 1'b0;

    cpu_top #(.reset_pc(reset_pc)) dut0 (.*);

    // LoongArch instruction formats
    function automatic logic [31:0] three_reg(input logic [16:0] op, input int rd,
                                              input int rj, input int rk);
        return {op, rk[4:0], rj[4:0], rd[4:0]};
    endfunction

    function automatic logic [31:0] reg_imm12(input logic [9:0] op, input int rd,
                                              input int rj, input int imm);
        return {op, imm[11:0], rj[4:0], rd[4:0]};
    endfunction

    function automatic logic [31:0] upper_imm20(input int rd, input int imm);
        return {7'h0a, imm[19:0], rd[4:0]};
    endfunction

    // offsets count instructions
    function automatic logic [31:0] reg_offs16(input logic [5:0] op, input int rd,
                                               input int rj, input int offs);
        return {op, offs[15:0], rj[4:0], rd[4:0]};
    endfunction

    function automatic logic [31:0] long_offs26(input logic [5:0] op, input int offs);
        return {op, offs[15:0], offs[25:16]};
    endfunction

    task automatic load_program();
        prog.push_back(upper_imm20(4, 'h12345));
        prog.push_back(reg_imm12(10'h00a, 4, 4, 'h678));
        prog.push_back(reg_imm12(10'h00a, 5, 4, -1));
        prog.push_back(three_reg(17'h00022, 6, 5, 4));
        prog.push_back(three_reg(17'h00024, 7, 6, 0));
        prog.push_back(three_reg(17'h00025, 8, 7, 6));
        prog.push_back(three_reg(17'h0002a, 9, 8, 4));
        prog.push_back(three_reg(17'h00029, 10, 9, 5));
        prog.push_back(three_reg(17'h00028, 11, 10, 0));
        prog.push_back(three_reg(17'h0002b, 12, 11, 4));
        prog.push_back(three_reg(17'h00081, 13, 12, 4));
        prog.push_back(three_reg(17'h00089, 14, 13, 8));
        prog.push_back(three_reg(17'h00091, 15, 13, 4));
        // r0 target, then read back
        prog.push_back(reg_imm12(10'h00a, 0, 15, 5));
        prog.push_back(three_reg(17'h00020, 16, 0, 15));
        prog.push_back(upper_imm20(17, 1));
        prog.push_back(reg_imm12(10'h0a6, 16, 17, 8));
        prog.push_back(reg_imm12(10'h0a2, 18, 17, 8));
        prog.push_back(reg_imm12(10'h00a, 19, 18, 1));
        prog.push_back(reg_imm12(10'h0a2, 20, 17, 'h40));
        prog.push_back(reg_offs16(6'h16, 20, 20, 2));
        prog.push_back(reg_imm12(10'h00a, 21, 0, 'h111));
        prog.push_back(reg_offs16(6'h17, 19, 19, 2));
        prog.push_back(reg_imm12(10'h00a, 21, 0, 'h222));
        prog.push_back(long_offs26(6'h15, 3));
        prog.push_back(reg_imm12(10'h00a, 22, 1, 0));
        prog.push_back(long_offs26(6'h14, 4));
        prog.push_back(reg_imm12(10'h00a, 23, 0, 'h333));
        prog.push_back(reg_offs16(6'h13, 0, 1, 0));
        prog.push_back(reg_imm12(10'h00a, 23, 0, 'h444));
        prog.push_back(long_offs26(6'h14, 0));
    endtask

    task automatic expect_write(input logic [31:0] offset, input int num,
                                input logic [31:0] value);
        exp_pc.push_back(reset_pc + offset);
        exp_num.push_back(num[4:0]);
        exp_data.push_back(value);
    endtask

    task automatic load_trace();
        expect_write('h00, 4, 32'h12345000);
        expect_write('h04, 4, 32'h12345678);
        expect_write('h08, 5, 32'h12345677);
        expect_write('h0c, 6, 32'hffffffff);
        expect_write('h10, 7, 32'h00000001);
        expect_write('h14, 8, 32'h00000001);
        expect_write('h18, 9, 32'h12345679);
        expect_write('h1c, 10, 32'h12345671);
        expect_write('h20, 11, 32'hedcba98e);
        expect_write('h24, 12, 32'hfffffff6);
        expect_write('h28, 13, 32'hffffff60);
        expect_write('h2c, 14, 32'h00ffffff);
        expect_write('h30, 15, 32'hfffffff6);
        expect_write('h34, 0, 32'hfffffffb);
        expect_write('h38, 16, 32'hfffffff6);
        expect_write('h3c, 17, 32'h00001000);
        expect_write('h44, 18, 32'hfffffff6);
        expect_write('h48, 19, 32'hfffffff7);
        expect_write('h4c, 20, 32'h5a000040);
        expect_write('h5c, 21, 32'h00000222);
        expect_write('h60, 1, 32'h1c000064);
        expect_write('h6c, 23, 32'h00000333);
        expect_write('h70, 0, 32'h1c000074);
        expect_write('h64, 22, 32'h1c000064);
    endtask

    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        logic [31:0] idx;
        logic [31:0] word;
        idx = (addr - reset_pc) >> 2;
        if (idx < prog.size()) begin
            word = prog[idx];
        end else begin
            word = 32'h0;
        end
        return word;
    endfunction

    task automatic stop_with_failure(input string msg);
        failed = 1'b1;
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic check_write();
        int k;
        if (trace_idx >= exp_pc.size()) begin
            stop_with_failure("register write seen after the expected trace ended");
        end else begin
            k = trace_idx;
            trace_idx = trace_idx + 1;
            assert (debug_wb_pc == exp_pc[k] && debug_wb_rf_wnum == exp_num[k]
                    && debug_wb_rf_wdata == exp_data[k])
            else begin
                stop_with_failure($sformatf(
                    "MISMATCH at %0t: pc %h r%0d = %h, expected pc %h r%0d = %h", $time,
                    debug_wb_pc, debug_wb_rf_wnum, debug_wb_rf_wdata,
                    exp_pc[k], exp_num[k], exp_data[k]));
            end
        end
    endtask

    // instruction port never writes
    task automatic check_inst_port();
        assert (inst_sram_we == 4'h0 && inst_sram_wdata == 32'h0)
        else begin
            stop_with_failure($sformatf(
                "MISMATCH at %0t: inst_sram_we %h inst_sram_wdata %h, expected zero",
                $time, inst_sram_we, inst_sram_wdata));
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        reset <= 1'b1;
        inst_sram_rdata <= 32'h0;
        data_sram_rdata <= 32'h0;
        // word address folded into every fill value
        for (int i = 0; i < 256; i++) begin
            dmem[i] <= 32'h5a000000 ^ (i * 4);
        end
        load_program();
        load_trace();
        repeat (4) @(posedge clk);
        reset <= 1'b0;
    end

    always @(posedge clk) begin
        if (inst_sram_en) begin
            inst_sram_rdata <= fetch_word(inst_sram_addr);
        end
    end

    always @(posedge clk) begin
        if (data_sram_en) begin
            for (int b = 0; b < 4; b++) begin
                if (data_sram_we[b]) begin
                    dmem[data_sram_addr[9:2]][8*b +: 8] <= data_sram_wdata[8*b +: 8];
                end
            end
            data_sram_rdata <= dmem[data_sram_addr[9:2]];
        end
    end

    // outputs settle by the falling edge
    always @(negedge clk) begin
        if (!reset) begin
            cycles = cycles + 1;
            check_inst_port();
            if (cycles > cycle_limit) begin
                stop_with_failure("timeout: trace incomplete");
            end else if (debug_wb_rf_we != 4'h0) begin
                check_write();
            end else if (trace_idx == exp_pc.size() && inst_sram_addr == loop_pc) begin
                passed = 1'b1;
                $display("SIMULATION PASSED");
                $finish;
            end
        end
    end

    final begin
        if (!passed && !failed) begin
            $display("SIMULATION FAILED");
        end
    end

endmodule

`default_nettype wire
